// ==== build.f ====
+incdir+.
pipeline_types.sv
decoder.sv
regfile.sv
dispatch.sv
execute.sv
ctrl.sv
backend_top.sv
tb_clock_gen.sv
tb_backend_top.sv

// ==== tb_backend_top.sv ====
`timescale 1ns/10ps
`include "backend_macros.svh"

module tb_backend_top;

    localparam int RESET_CYCLES = 10;

    typedef struct packed {
        logic [31:0] pc;
        logic        we;
        logic [4:0]  rd;
        logic [31:0] data;
    } commit_t;

    logic        clk;
    logic        rst_i;
    logic        inst_valid_i;
    logic [31:0] pc_i;
    logic [31:0] inst_i;
    logic        pre_is_branch_taken_i;
    logic [31:0] pre_branch_addr_i;
    logic        send_inst_en_o;
    logic        flush_o;
    logic [31:0] new_pc_o;
    logic        commit_valid_o;
    logic [31:0] commit_pc_o;
    logic        commit_we_o;
    logic [4:0]  commit_rd_o;
    logic [31:0] commit_data_o;

    logic [31:0] model_regs [32];
    commit_t     exp_q [$];
    logic [31:0] cur_pc;
    logic [31:0] flush_pc;
    logic [31:0] seed_val;
    logic [31:0] rnd;
    int          issued;
    int          stall_cycles;
    int          flush_count;
    int          exp_flushes;
    logic [16:0] alu_ops [5] = '{`OP_3R_ADD, `OP_3R_SUB, `OP_3R_AND, `OP_3R_OR, `OP_3R_XOR};

    tb_clock_gen #(.PERIOD(20), .RESET_CYCLES(RESET_CYCLES)) u_clock_gen (
        .clk_o(clk),
        .rst_o(rst_i)
    );

    backend_top dut_i (
        .clk, .rst_i, .inst_valid_i, .pc_i, .inst_i,
        .pre_is_branch_taken_i, .pre_branch_addr_i,
        .send_inst_en_o, .flush_o, .new_pc_o,
        .commit_valid_o, .commit_pc_o, .commit_we_o, .commit_rd_o, .commit_data_o
    );

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR: %s is 0x%08h, expected 0x%08h", name, actual, expected);
            stop_with_failure("first mismatch reached");
        end
    endtask

    function automatic logic [31:0] three_reg_word(input logic [16:0] op, input int rd,
                                                   input int rj, input int rk);
        return {op, rk[4:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic logic [31:0] addi_word(input int rd, input int rj,
                                              input logic [11:0] si12);
        return {`OP_ADDI_W, si12, rj[4:0], rd[4:0]};
    endfunction

    function automatic logic [31:0] lu12i_word(input int rd, input logic [19:0] si20);
        return {`OP_LU12I_W, si20, rd[4:0]};
    endfunction

    function automatic logic [31:0] branch_word(input logic bne, input int rj, input int rd,
                                                input logic [15:0] offs);
        return {(bne ? `OP_BNE : `OP_BEQ), offs, rj[4:0], rd[4:0]};
    endfunction

    // hold the word until consumed, or until a redirect turns it away
    task automatic send_inst(input logic [31:0] word, input logic [31:0] pc,
                             input logic pre_taken, input logic [31:0] pre_target,
                             output logic dropped);
        logic done;
        done                  = 1'b0;
        dropped               = 1'b0;
        inst_valid_i          = 1'b1;
        inst_i                = word;
        pc_i                  = pc;
        pre_is_branch_taken_i = pre_taken;
        pre_branch_addr_i     = pre_target;
        issued++;
        while (!done) begin
            #1;
            if (send_inst_en_o) begin
                done = 1'b1;
            end else if (flush_o) begin
                done    = 1'b1;
                dropped = 1'b1;
            end else begin
                stall_cycles++;
            end
            @(negedge clk);
        end
        inst_valid_i = 1'b0;
    endtask

    task automatic send_expected(input logic [31:0] word, input int rd, input logic [31:0] data);
        logic dropped;
        exp_q.push_back({cur_pc, rd != 0, rd[4:0], data});
        if (rd != 0) begin
            model_regs[rd] = data;
        end
        send_inst(word, cur_pc, 1'b0, cur_pc + 32'd4, dropped);
        if (dropped) begin
            stop_with_failure("instruction refused while no redirect was due");
        end
        cur_pc += 32'd4;
    endtask

    task automatic three_reg(input logic [16:0] op, input int rd, input int rj, input int rk);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        a = model_regs[rj];
        b = model_regs[rk];
        case (op)
            `OP_3R_ADD: r = a + b;
            `OP_3R_SUB: r = a - b;
            `OP_3R_AND: r = a & b;
            `OP_3R_OR:  r = a | b;
            `OP_3R_XOR: r = a ^ b;
            default:    r = a * b;
        endcase
        send_expected(three_reg_word(op, rd, rj, rk), rd, r);
    endtask

    task automatic add_imm(input int rd, input int rj, input logic [11:0] si12);
        send_expected(addi_word(rd, rj, si12), rd, model_regs[rj] + {{20{si12[11]}}, si12});
    endtask

    task automatic load_upper(input int rd, input logic [19:0] si20);
        send_expected(lu12i_word(rd, si20), rd, {si20, 12'h000});
    endtask

    task automatic branch_inst(input logic bne, input int rj, input int rd,
                               input logic [15:0] offs, input logic pre_taken,
                               input logic [31:0] pre_target);
        logic        taken;
        logic        dropped;
        logic [31:0] target;
        logic [31:0] wrong_pc;
        taken  = bne ? (model_regs[rj] != model_regs[rd]) : (model_regs[rj] == model_regs[rd]);
        target = taken ? cur_pc + {{14{offs[15]}}, offs, 2'b00} : cur_pc + 32'd4;
        exp_q.push_back({cur_pc, 1'b0, 5'd0, 32'd0});
        send_inst(branch_word(bne, rj, rd, offs), cur_pc, pre_taken, pre_target, dropped);
        if (dropped) begin
            stop_with_failure("branch refused at the input");
        end
        if (taken != pre_taken || (taken && pre_target != target)) begin
            exp_flushes++;
            // two wrong-path words that would clobber r20 if they leaked
            wrong_pc = pre_taken ? pre_target : cur_pc + 32'd4;
            send_inst(addi_word(20, 0, 12'h5a5), wrong_pc, 1'b0, wrong_pc + 32'd4, dropped);
            send_inst(addi_word(20, 0, 12'h3c3), wrong_pc + 32'd4, 1'b0, wrong_pc, dropped);
            if (!dropped) begin
                stop_with_failure("second wrong-path instruction accepted during redirect");
            end
            check_eq("new_pc_o", flush_pc, target);
        end
        cur_pc = target;
    endtask

    task automatic drain;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        check_eq("flush_o pulse count", flush_count, exp_flushes);
    endtask

    task automatic idle_after_reset;
        repeat (5) begin
            @(negedge clk);
            check_eq("commit_valid_o", commit_valid_o, 1'b0);
            check_eq("flush_o", flush_o, 1'b0);
            check_eq("send_inst_en_o", send_inst_en_o, 1'b0);
        end
    endtask

    task automatic random_alu_ops;
        for (int r = 1; r <= 8; r++) begin
            rnd = $urandom();
            load_upper(r, rnd[31:12]);
            add_imm(r, r, rnd[11:0]);
        end
        for (int n = 0; n < 15; n++) begin
            three_reg(alu_ops[n % 5], $urandom() % 15 + 1, $urandom() % 9, $urandom() % 9);
        end
        drain();
    endtask

    task automatic forwarding_and_r0;
        rnd = $urandom();
        load_upper(10, rnd[31:12]);
        add_imm(10, 10, 12'h123);
        three_reg(`OP_3R_ADD, 11, 10, 10);
        three_reg(`OP_3R_SUB, 12, 1, 11);
        three_reg(`OP_3R_XOR, 13, 11, 2);
        // distance 3 on r11, distance 2 on r12
        three_reg(`OP_3R_OR, 14, 11, 12);
        three_reg(`OP_3R_ADD, 0, 1, 2);
        add_imm(0, 3, 12'h7ff);
        three_reg(`OP_3R_ADD, 15, 0, 3);
        three_reg(`OP_3R_OR, 16, 0, 0);
        drain();
    endtask

    task automatic multiply_stall;
        stall_cycles = 0;
        three_reg(`OP_3R_MUL, 17, 1, 2);
        three_reg(`OP_3R_ADD, 18, 17, 3);
        three_reg(`OP_3R_XOR, 19, 18, 17);
        check_eq("send_inst_en_o low cycles", stall_cycles, 1);
        three_reg(`OP_3R_MUL, 21, 19, 4);
        three_reg(`OP_3R_MUL, 22, 21, 21);
        drain();
    endtask

    task automatic mispredicted_branches;
        add_imm(23, 1, 12'h000);
        branch_inst(1'b0, 1, 23, 16'h0010, 1'b0, 32'h0);
        three_reg(`OP_3R_ADD, 24, 23, 2);
        branch_inst(1'b1, 1, 23, 16'h0020, 1'b1, cur_pc + 32'h80);
        three_reg(`OP_3R_SUB, 25, 24, 1);
        // taken as predicted, but to the wrong place
        branch_inst(1'b0, 23, 1, 16'hfff8, 1'b1, cur_pc + 32'h40);
        three_reg(`OP_3R_AND, 26, 25, 24);
        drain();
    endtask

    task automatic predicted_branches;
        branch_inst(1'b0, 1, 23, 16'h0010, 1'b1, cur_pc + 32'h40);
        three_reg(`OP_3R_XOR, 27, 24, 25);
        branch_inst(1'b1, 1, 23, 16'h0030, 1'b0, cur_pc + 32'h4);
        add_imm(28, 27, 12'h801);
        branch_inst(1'b1, 1, 2, 16'hfff0, model_regs[1] != model_regs[2], cur_pc - 32'd64);
        three_reg(`OP_3R_OR, 29, 28, 27);
        drain();
    endtask

    always @(negedge clk) begin : commit_monitor
        commit_t want;
        if (!rst_i && flush_o) begin
            flush_count++;
            flush_pc = new_pc_o;
        end
        if (!rst_i && commit_valid_o) begin
            if (exp_q.size() == 0) begin
                stop_with_failure("commit seen with no instruction expected");
            end else begin
                want = exp_q.pop_front();
                check_eq("commit_pc_o", commit_pc_o, want.pc);
                check_eq("commit_we_o", commit_we_o, want.we);
                if (want.we) begin
                    check_eq("commit_rd_o", commit_rd_o, want.rd);
                    check_eq("commit_data_o", commit_data_o, want.data);
                end
            end
        end
    end

    // budget grows with every instruction handed to the DUT
    initial begin : watchdog
        int cycles;
        cycles = 0;
        forever begin
            @(negedge clk);
            cycles++;
            if (cycles > RESET_CYCLES + 200 * (issued + 1)) begin
                stop_with_failure("watchdog expired, the run hung");
            end
        end
    end

    initial begin
        inst_valid_i          = 1'b0;
        pc_i                  = '0;
        inst_i                = '0;
        pre_is_branch_taken_i = 1'b0;
        pre_branch_addr_i     = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        issued       = 0;
        stall_cycles = 0;
        flush_count  = 0;
        exp_flushes  = 0;
        cur_pc       = 32'h1c00_0000;
        seed_val     = $urandom(32'h9867);
        @(negedge rst_i);
        idle_after_reset();
        random_alu_ops();
        forwarding_and_r0();
        multiply_stall();
        mispredicted_branches();
        predicted_branches();
        if (exp_q.size() == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            stop_with_failure("expected commits never arrived");
        end
    end

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // released on a falling edge, away from the sampling edge
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule

// ==== backend_top.sv ====
`timescale 1ns/10ps

module backend_top (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic                      inst_valid_i,
    input  pipeline_types::bus32_t    pc_i,
    input  pipeline_types::bus32_t    inst_i,
    input  logic                      pre_is_branch_taken_i,
    input  pipeline_types::bus32_t    pre_branch_addr_i,
    output logic                      send_inst_en_o,
    output logic                      flush_o,
    output pipeline_types::bus32_t    new_pc_o,
    output logic                      commit_valid_o,
    output pipeline_types::bus32_t    commit_pc_o,
    output logic                      commit_we_o,
    output pipeline_types::reg_addr_t commit_rd_o,
    output pipeline_types::bus32_t    commit_data_o
);

    pipeline_types::pipe_ctrl_t pause;
    pipeline_types::pipe_ctrl_t flush_vec;

    // decode to dispatch
    logic                      id_valid;
    pipeline_types::alu_op_t   id_op;
    pipeline_types::reg_addr_t id_rd;
    pipeline_types::reg_addr_t id_rj;
    pipeline_types::reg_addr_t id_rk;
    pipeline_types::bus32_t    id_imm;
    pipeline_types::bus32_t    id_pc;
    logic                      id_pre_taken;
    pipeline_types::bus32_t    id_pre_target;

    // regfile
    pipeline_types::reg_addr_t raddr_a;
    pipeline_types::reg_addr_t raddr_b;
    pipeline_types::bus32_t    rdata_a;
    pipeline_types::bus32_t    rdata_b;
    logic                      reg_write_en;
    pipeline_types::reg_addr_t reg_write_addr;
    pipeline_types::bus32_t    reg_write_data;

    // dispatch to execute
    logic                      ds_valid;
    pipeline_types::alu_op_t   ds_op;
    pipeline_types::reg_addr_t ds_rd;
    pipeline_types::bus32_t    ds_src1;
    pipeline_types::bus32_t    ds_src2;
    pipeline_types::bus32_t    ds_imm;
    pipeline_types::bus32_t    ds_pc;
    logic                      ds_pre_taken;
    pipeline_types::bus32_t    ds_pre_target;

    // execute outputs
    logic                      ex_fwd_we;
    pipeline_types::reg_addr_t ex_fwd_rd;
    pipeline_types::bus32_t    ex_fwd_data;
    logic                      pause_ex_req;
    logic                      branch_flush_req;
    pipeline_types::bus32_t    branch_target;
    logic                      wb_valid;
    pipeline_types::bus32_t    wb_pc;
    logic                      wb_we;
    pipeline_types::reg_addr_t wb_rd;
    pipeline_types::bus32_t    wb_data;

    decoder u_decoder (
        .clk, .rst_i,
        .pause_i(pause[0]), .flush_i(flush_vec[0]),
        .inst_valid_i, .pc_i, .inst_i,
        .pre_taken_i(pre_is_branch_taken_i), .pre_target_i(pre_branch_addr_i),
        .id_valid_o(id_valid), .id_op_o(id_op), .id_rd_o(id_rd),
        .id_rj_o(id_rj), .id_rk_o(id_rk), .id_imm_o(id_imm), .id_pc_o(id_pc),
        .id_pre_taken_o(id_pre_taken), .id_pre_target_o(id_pre_target)
    );

    dispatch u_dispatch (
        .clk, .rst_i,
        .pause_i(pause[1]), .flush_i(flush_vec[1]),
        .id_valid_i(id_valid), .id_op_i(id_op), .id_rd_i(id_rd),
        .id_rj_i(id_rj), .id_rk_i(id_rk), .id_imm_i(id_imm), .id_pc_i(id_pc),
        .id_pre_taken_i(id_pre_taken), .id_pre_target_i(id_pre_target),
        .raddr_a_o(raddr_a), .raddr_b_o(raddr_b),
        .rdata_a_i(rdata_a), .rdata_b_i(rdata_b),
        .ex_fwd_we_i(ex_fwd_we), .ex_fwd_rd_i(ex_fwd_rd), .ex_fwd_data_i(ex_fwd_data),
        .wb_fwd_we_i(wb_we), .wb_fwd_rd_i(wb_rd), .wb_fwd_data_i(wb_data),
        .ds_valid_o(ds_valid), .ds_op_o(ds_op), .ds_rd_o(ds_rd),
        .ds_src1_o(ds_src1), .ds_src2_o(ds_src2), .ds_imm_o(ds_imm), .ds_pc_o(ds_pc),
        .ds_pre_taken_o(ds_pre_taken), .ds_pre_target_o(ds_pre_target)
    );

    execute u_execute (
        .clk, .rst_i,
        .pause_i(pause[2]), .flush_i(flush_vec[2]),
        .ds_valid_i(ds_valid), .ds_op_i(ds_op), .ds_rd_i(ds_rd),
        .ds_src1_i(ds_src1), .ds_src2_i(ds_src2), .ds_imm_i(ds_imm), .ds_pc_i(ds_pc),
        .ds_pre_taken_i(ds_pre_taken), .ds_pre_target_i(ds_pre_target),
        .ex_fwd_we_o(ex_fwd_we), .ex_fwd_rd_o(ex_fwd_rd), .ex_fwd_data_o(ex_fwd_data),
        .pause_ex_req_o(pause_ex_req), .branch_flush_req_o(branch_flush_req),
        .branch_target_o(branch_target),
        .wb_valid_o(wb_valid), .wb_pc_o(wb_pc), .wb_we_o(wb_we),
        .wb_rd_o(wb_rd), .wb_data_o(wb_data)
    );

    regfile u_regfile (
        .clk, .rst_i,
        .raddr_a_i(raddr_a), .raddr_b_i(raddr_b),
        .rdata_a_o(rdata_a), .rdata_b_o(rdata_b),
        .we_i(reg_write_en), .waddr_i(reg_write_addr), .wdata_i(reg_write_data)
    );

    ctrl u_ctrl (
        .clk, .rst_i, .inst_valid_i,
        .pause_ex_req_i(pause_ex_req), .branch_flush_req_i(branch_flush_req),
        .branch_target_i(branch_target),
        .wb_valid_i(wb_valid), .wb_pc_i(wb_pc), .wb_we_i(wb_we),
        .wb_rd_i(wb_rd), .wb_data_i(wb_data),
        .pause_o(pause), .flush_o, .flush_vec_o(flush_vec), .new_pc_o, .send_inst_en_o,
        .reg_write_en_o(reg_write_en), .reg_write_addr_o(reg_write_addr),
        .reg_write_data_o(reg_write_data),
        .commit_valid_o, .commit_pc_o, .commit_we_o, .commit_rd_o, .commit_data_o
    );

endmodule

// ==== ctrl.sv ====
`timescale 1ns/10ps

module ctrl (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic                       inst_valid_i,
    input  logic                       pause_ex_req_i,
    input  logic                       branch_flush_req_i,
    input  pipeline_types::bus32_t     branch_target_i,
    input  logic                       wb_valid_i,
    input  pipeline_types::bus32_t     wb_pc_i,
    input  logic                       wb_we_i,
    input  pipeline_types::reg_addr_t  wb_rd_i,
    input  pipeline_types::bus32_t     wb_data_i,
    output pipeline_types::pipe_ctrl_t pause_o,
    output logic                       flush_o,
    output pipeline_types::pipe_ctrl_t flush_vec_o,
    output pipeline_types::bus32_t     new_pc_o,
    output logic                       send_inst_en_o,
    output logic                       reg_write_en_o,
    output pipeline_types::reg_addr_t  reg_write_addr_o,
    output pipeline_types::bus32_t     reg_write_data_o,
    output logic                       commit_valid_o,
    output pipeline_types::bus32_t     commit_pc_o,
    output logic                       commit_we_o,
    output pipeline_types::reg_addr_t  commit_rd_o,
    output pipeline_types::bus32_t     commit_data_o
);

    // bit 0 decode, 1 dispatch, 2 execute, 3 writeback
    assign flush_o     = branch_flush_req_i;
    assign flush_vec_o = flush_o ? 4'b0011 : 4'b0000;
    // redirect wins over the multiply stall
    assign pause_o     = (!flush_o && pause_ex_req_i) ? 4'b0111 : 4'b0000;
    assign new_pc_o    = branch_target_i;

    assign send_inst_en_o = inst_valid_i && !pause_o[0] && !flush_o;

    assign reg_write_en_o   = wb_valid_i && wb_we_i;
    assign reg_write_addr_o = wb_rd_i;
    assign reg_write_data_o = wb_data_i;

    assign commit_valid_o = wb_valid_i;
    assign commit_pc_o    = wb_pc_i;
    assign commit_we_o    = wb_valid_i && wb_we_i;
    assign commit_rd_o    = wb_rd_i;
    assign commit_data_o  = wb_data_i;

    // one instruction in execute never asks to hold and clear the same stages
    a_no_pause_and_flush: assert property (@(posedge clk) disable iff (rst_i)
        !(pause_ex_req_i && branch_flush_req_i));

endmodule

// ==== execute.sv ====
`timescale 1ns/10ps

module execute (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic                      pause_i,
    input  logic                      flush_i,
    input  logic                      ds_valid_i,
    input  pipeline_types::alu_op_t   ds_op_i,
    input  pipeline_types::reg_addr_t ds_rd_i,
    input  pipeline_types::bus32_t    ds_src1_i,
    input  pipeline_types::bus32_t    ds_src2_i,
    input  pipeline_types::bus32_t    ds_imm_i,
    input  pipeline_types::bus32_t    ds_pc_i,
    input  logic                      ds_pre_taken_i,
    input  pipeline_types::bus32_t    ds_pre_target_i,
    output logic                      ex_fwd_we_o,
    output pipeline_types::reg_addr_t ex_fwd_rd_o,
    output pipeline_types::bus32_t    ex_fwd_data_o,
    output logic                      pause_ex_req_o,
    output logic                      branch_flush_req_o,
    output pipeline_types::bus32_t    branch_target_o,
    output logic                      wb_valid_o,
    output pipeline_types::bus32_t    wb_pc_o,
    output logic                      wb_we_o,
    output pipeline_types::reg_addr_t wb_rd_o,
    output pipeline_types::bus32_t    wb_data_o
);

    pipeline_types::mul_state_t mul_state;
    pipeline_types::bus32_t     mul_q;
    logic                       is_branch;
    logic                       taken;

    always_comb begin
        case (ds_op_i)
            // imm is zero for 3R add and rk is r0 for addi
            pipeline_types::ALU_ADD: ex_fwd_data_o = ds_src1_i + ds_src2_i + ds_imm_i;
            pipeline_types::ALU_SUB: ex_fwd_data_o = ds_src1_i - ds_src2_i;
            pipeline_types::ALU_AND: ex_fwd_data_o = ds_src1_i & ds_src2_i;
            pipeline_types::ALU_OR:  ex_fwd_data_o = ds_src1_i | ds_src2_i;
            pipeline_types::ALU_XOR: ex_fwd_data_o = ds_src1_i ^ ds_src2_i;
            pipeline_types::ALU_MUL: ex_fwd_data_o = mul_q;
            pipeline_types::ALU_LUI: ex_fwd_data_o = ds_imm_i;
            default:                 ex_fwd_data_o = '0;
        endcase
    end

    assign pause_ex_req_o = ds_valid_i && ds_op_i == pipeline_types::ALU_MUL
                            && mul_state == pipeline_types::MUL_IDLE;
    assign ex_fwd_we_o    = ds_valid_i && ds_rd_i != '0 && !pause_ex_req_o;
    assign ex_fwd_rd_o    = ds_rd_i;

    // branch resolution
    assign is_branch = ds_op_i == pipeline_types::ALU_BEQ || ds_op_i == pipeline_types::ALU_BNE;
    assign taken     = (ds_op_i == pipeline_types::ALU_BEQ) ? (ds_src1_i == ds_src2_i)
                                                            : (ds_src1_i != ds_src2_i);
    assign branch_target_o = taken ? ds_pc_i + ds_imm_i : ds_pc_i + 32'd4;
    assign branch_flush_req_o = ds_valid_i && is_branch
        && (taken != ds_pre_taken_i || (taken && ds_pre_target_i != branch_target_o));

    // product held for the second multiply cycle
    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            mul_state <= pipeline_types::MUL_IDLE;
        end else if (pause_ex_req_o) begin
            mul_state <= pipeline_types::MUL_BUSY;
        end else begin
            mul_state <= pipeline_types::MUL_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (pause_ex_req_o) begin
            mul_q <= ds_src1_i * ds_src2_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || flush_i || pause_i) begin
            // bubble while the multiply is in its first cycle
            wb_valid_o <= 1'b0;
            wb_we_o    <= 1'b0;
        end else begin
            wb_valid_o <= ds_valid_i;
            wb_we_o    <= ex_fwd_we_o;
        end
    end

    always_ff @(posedge clk) begin
        wb_pc_o   <= ds_pc_i;
        wb_rd_o   <= ds_rd_i;
        wb_data_o <= ex_fwd_data_o;
    end

    // the held multiply is still in execute for its one busy cycle
    a_mul_one_busy: assert property (@(posedge clk) disable iff (rst_i)
        (mul_state == pipeline_types::MUL_BUSY)
        |-> (ds_valid_i && ds_op_i == pipeline_types::ALU_MUL)
            ##1 (mul_state == pipeline_types::MUL_IDLE));

endmodule

// ==== dispatch.sv ====
`timescale 1ns/10ps

module dispatch (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic                      pause_i,
    input  logic                      flush_i,
    input  logic                      id_valid_i,
    input  pipeline_types::alu_op_t   id_op_i,
    input  pipeline_types::reg_addr_t id_rd_i,
    input  pipeline_types::reg_addr_t id_rj_i,
    input  pipeline_types::reg_addr_t id_rk_i,
    input  pipeline_types::bus32_t    id_imm_i,
    input  pipeline_types::bus32_t    id_pc_i,
    input  logic                      id_pre_taken_i,
    input  pipeline_types::bus32_t    id_pre_target_i,
    output pipeline_types::reg_addr_t raddr_a_o,
    output pipeline_types::reg_addr_t raddr_b_o,
    input  pipeline_types::bus32_t    rdata_a_i,
    input  pipeline_types::bus32_t    rdata_b_i,
    input  logic                      ex_fwd_we_i,
    input  pipeline_types::reg_addr_t ex_fwd_rd_i,
    input  pipeline_types::bus32_t    ex_fwd_data_i,
    input  logic                      wb_fwd_we_i,
    input  pipeline_types::reg_addr_t wb_fwd_rd_i,
    input  pipeline_types::bus32_t    wb_fwd_data_i,
    output logic                      ds_valid_o,
    output pipeline_types::alu_op_t   ds_op_o,
    output pipeline_types::reg_addr_t ds_rd_o,
    output pipeline_types::bus32_t    ds_src1_o,
    output pipeline_types::bus32_t    ds_src2_o,
    output pipeline_types::bus32_t    ds_imm_o,
    output pipeline_types::bus32_t    ds_pc_o,
    output logic                      ds_pre_taken_o,
    output pipeline_types::bus32_t    ds_pre_target_o
);

    // youngest producer wins, r0 never forwarded
    function automatic pipeline_types::bus32_t pick(input pipeline_types::reg_addr_t addr,
                                                    input pipeline_types::bus32_t rf_data);
        if (addr != '0 && ex_fwd_we_i && ex_fwd_rd_i == addr) begin
            return ex_fwd_data_i;
        end
        if (addr != '0 && wb_fwd_we_i && wb_fwd_rd_i == addr) begin
            return wb_fwd_data_i;
        end
        return rf_data;
    endfunction

    assign raddr_a_o = id_rj_i;
    assign raddr_b_o = id_rk_i;

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            ds_valid_o <= 1'b0;
        end else if (!pause_i) begin
            ds_valid_o <= id_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!pause_i) begin
            ds_op_o         <= id_op_i;
            ds_rd_o         <= id_rd_i;
            ds_src1_o       <= pick(id_rj_i, rdata_a_i);
            ds_src2_o       <= pick(id_rk_i, rdata_b_i);
            ds_imm_o        <= id_imm_i;
            ds_pc_o         <= id_pc_i;
            ds_pre_taken_o  <= id_pre_taken_i;
            ds_pre_target_o <= id_pre_target_i;
        end
    end

endmodule

// ==== regfile.sv ====
`timescale 1ns/10ps

module regfile (
    input  logic                      clk,
    input  logic                      rst_i,
    input  pipeline_types::reg_addr_t raddr_a_i,
    input  pipeline_types::reg_addr_t raddr_b_i,
    output pipeline_types::bus32_t    rdata_a_o,
    output pipeline_types::bus32_t    rdata_b_o,
    input  logic                      we_i,
    input  pipeline_types::reg_addr_t waddr_i,
    input  pipeline_types::bus32_t    wdata_i
);

    pipeline_types::bus32_t regs [32];

    // write-through on a same-cycle hit
    assign rdata_a_o = (we_i && waddr_i != '0 && waddr_i == raddr_a_i) ? wdata_i
                                                                        : regs[raddr_a_i];
    assign rdata_b_o = (we_i && waddr_i != '0 && waddr_i == raddr_b_i) ? wdata_i
                                                                        : regs[raddr_b_i];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // r0 reads zero on both ports, write-through included
    a_r0_stays_zero: assert property (@(posedge clk) disable iff (rst_i)
        (raddr_a_i != '0 || rdata_a_o == '0) && (raddr_b_i != '0 || rdata_b_o == '0));

endmodule

// ==== decoder.sv ====
`timescale 1ns/10ps
`include "backend_macros.svh"

module decoder (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic                      pause_i,
    input  logic                      flush_i,
    input  logic                      inst_valid_i,
    input  pipeline_types::bus32_t    pc_i,
    input  pipeline_types::bus32_t    inst_i,
    input  logic                      pre_taken_i,
    input  pipeline_types::bus32_t    pre_target_i,
    output logic                      id_valid_o,
    output pipeline_types::alu_op_t   id_op_o,
    output pipeline_types::reg_addr_t id_rd_o,
    output pipeline_types::reg_addr_t id_rj_o,
    output pipeline_types::reg_addr_t id_rk_o,
    output pipeline_types::bus32_t    id_imm_o,
    output pipeline_types::bus32_t    id_pc_o,
    output logic                      id_pre_taken_o,
    output pipeline_types::bus32_t    id_pre_target_o
);

    pipeline_types::alu_op_t   op_d;
    pipeline_types::reg_addr_t rd_d;
    pipeline_types::reg_addr_t rk_d;
    pipeline_types::bus32_t    imm_d;

    always_comb begin
        op_d  = pipeline_types::ALU_NOP;
        rd_d  = inst_i[4:0];
        rk_d  = inst_i[14:10];
        imm_d = '0;
        case (inst_i[31:15])
            `OP_3R_ADD: op_d = pipeline_types::ALU_ADD;
            `OP_3R_SUB: op_d = pipeline_types::ALU_SUB;
            `OP_3R_AND: op_d = pipeline_types::ALU_AND;
            `OP_3R_OR:  op_d = pipeline_types::ALU_OR;
            `OP_3R_XOR: op_d = pipeline_types::ALU_XOR;
            `OP_3R_MUL: op_d = pipeline_types::ALU_MUL;
            default: begin
                if (inst_i[31:22] == `OP_ADDI_W) begin
                    // shares the adder, r0 as second source
                    op_d  = pipeline_types::ALU_ADD;
                    rk_d  = '0;
                    imm_d = {{20{inst_i[21]}}, inst_i[21:10]};
                end else if (inst_i[31:25] == `OP_LU12I_W) begin
                    op_d  = pipeline_types::ALU_LUI;
                    imm_d = {inst_i[24:5], 12'b0};
                end else if (inst_i[31:26] == `OP_BEQ || inst_i[31:26] == `OP_BNE) begin
                    op_d  = inst_i[26] ? pipeline_types::ALU_BNE : pipeline_types::ALU_BEQ;
                    // rd field is the second compare source
                    rk_d  = inst_i[4:0];
                    rd_d  = '0;
                    imm_d = {{14{inst_i[25]}}, inst_i[25:10], 2'b00};
                end else begin
                    // unknown, valid nop with no write
                    rd_d = '0;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            id_valid_o <= 1'b0;
        end else if (!pause_i) begin
            id_valid_o <= inst_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!pause_i) begin
            id_op_o         <= op_d;
            id_rd_o         <= rd_d;
            id_rj_o         <= inst_i[9:5];
            id_rk_o         <= rk_d;
            id_imm_o        <= imm_d;
            id_pc_o         <= pc_i;
            id_pre_taken_o  <= pre_taken_i;
            id_pre_target_o <= pre_target_i;
        end
    end

endmodule

// ==== pipeline_types.sv ====
`include "backend_macros.svh"

package pipeline_types;

    typedef logic [`REG_WIDTH-1:0] bus32_t;
    typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;

    // one bit per stage
    typedef logic [`PIPE_WIDTH-1:0] pipe_ctrl_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_MUL,
        ALU_LUI,
        ALU_BEQ,
        ALU_BNE,
        ALU_NOP
    } alu_op_t;

    typedef enum logic {MUL_IDLE, MUL_BUSY} mul_state_t;

endpackage

// ==== backend_macros.svh ====
`ifndef BACKEND_MACROS_SVH
`define BACKEND_MACROS_SVH

`define REG_WIDTH       32
`define REG_ADDR_WIDTH  5
// decode, dispatch, execute, writeback
`define PIPE_WIDTH      4

// 3R format, inst[31:15]
`define OP_3R_ADD       17'h00020
`define OP_3R_SUB       17'h00022
`define OP_3R_AND       17'h00029
`define OP_3R_OR        17'h0002a
`define OP_3R_XOR       17'h0002b
`define OP_3R_MUL       17'h00038

// 2RI12, inst[31:22]
`define OP_ADDI_W       10'h00a
// 1RI20, inst[31:25]
`define OP_LU12I_W      7'h0a
// 2RI16, inst[31:26]
`define OP_BEQ          6'h16
`define OP_BNE          6'h17

`endif
